// ==== common/mouse_pkg.sv ====
////////////////////////////////////////
// Widths, command format and state encodings shared by the design
// GPIO_W fixes the 4-byte payload of a command, so it is not a parameter
////////////////////////////////////////

package mouse_pkg;

    // Board and register bus widths
    localparam int unsigned GPIO_W     = 32;
    localparam int unsigned BOARD_IO_W = 42;
    localparam int unsigned ADDR_W     = 2;

    // Response byte sent after every write
    localparam logic [7:0] ACK_BYTE = 8'h06;

    // Opcode, bit 7 of the command byte
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } cmd_op_e;

    // Register map, bits 1..0 of the command byte
    typedef enum logic [ADDR_W-1:0] {
        REG_OUT  = 2'd0,
        REG_OE   = 2'd1,
        REG_IN   = 2'd2,   // read only
        REG_NONE = 2'd3    // unmapped, reads as 0
    } gpio_reg_e;

    // Command bridge FSM
    typedef enum logic [1:0] {
        ST_CMD,
        ST_DATA,
        ST_BUS,
        ST_SEND
    } bridge_state_e;

    // Shared by receiver and transmitter
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } uart_state_e;

endpackage

// ==== common/mouse_bus_if.sv ====
////////////////////////////////////////
// Register bus, single-cycle req strobe without back-pressure
// Read data returns with rvalid exactly one cycle after req
////////////////////////////////////////
`timescale 1ns/1ps

interface mouse_bus_if;
    import mouse_pkg::*;

    // Request side
    logic              req;
    logic              wen;
    logic [ADDR_W-1:0] addr;
    logic [GPIO_W-1:0] wdata;
    // Response side
    logic [GPIO_W-1:0] rdata;
    logic              rvalid;

    // Command bridge
    modport master (output req, wen, addr, wdata, input rdata, rvalid);

    // Register block
    modport slave (input req, wen, addr, wdata, output rdata, rvalid);

endinterface

// ==== uart/uart_rx.sv ====
////////////////////////////////////////
// UART receiver, 8N1, BAUD_DIV clocks per bit
// Frames with a low stop bit are dropped without notice
////////////////////////////////////////
`timescale 1ns/1ps

module uart_rx #(
    parameter int unsigned BAUD_DIV = 868
)(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic       rx_valid,
    output logic [7:0] rx_data
);
    import mouse_pkg::*;

    localparam int unsigned CNT_W = $clog2(BAUD_DIV + 1);

    uart_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;
    // Two sync flops plus one for edge detect
    logic [2:0]       rxd_sync;
    logic             rxd_s;
    logic             fall;

    assign rxd_s   = rxd_sync[1];
    assign fall    = rxd_sync[2] & ~rxd_sync[1];
    assign rx_data = shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync <= 3'b111;
            state    <= IDLE;
            cnt      <= '0;
            bit_idx  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[1:0], rxd};
            rx_valid <= 1'b0;
            if (cnt != '0) begin
                cnt <= cnt - 1'b1;
            end
            case (state)
                IDLE: begin
                    // Half a bit to reach the middle of the start bit
                    if (fall) begin
                        state <= START;
                        cnt   <= CNT_W'(BAUD_DIV / 2 - 1);
                    end
                end
                START: begin
                    if (cnt == '0) begin
                        // Glitch if the line is high again
                        state   <= rxd_s ? IDLE : DATA;
                        cnt     <= CNT_W'(BAUD_DIV - 1);
                        bit_idx <= '0;
                    end
                end
                DATA: begin
                    if (cnt == '0) begin
                        cnt     <= CNT_W'(BAUD_DIV - 1);
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            state <= STOP;
                        end
                    end
                end
                STOP: begin
                    // Mid stop bit, strobe only on a valid frame
                    if (cnt == '0) begin
                        state    <= IDLE;
                        rx_valid <= rxd_s;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // LSB arrives first
    always_ff @(posedge clk) begin
        if (state == DATA && cnt == '0) begin
            shift <= {rxd_s, shift[7:1]};
        end
    end

endmodule

// ==== uart/uart_tx.sv ====
////////////////////////////////////////
// UART transmitter, 8N1, BAUD_DIV clocks per bit
// tx_start is only honoured while tx_busy is low
////////////////////////////////////////
`timescale 1ns/1ps

module uart_tx #(
    parameter int unsigned BAUD_DIV = 868
)(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       tx_start,
    input  logic [7:0] tx_data,
    output logic       txd,
    output logic       tx_busy
);
    import mouse_pkg::*;

    localparam int unsigned CNT_W = $clog2(BAUD_DIV + 1);

    uart_state_e      state;
    logic [CNT_W-1:0] cnt;
    logic [2:0]       bit_idx;
    logic [7:0]       shift;

    // Busy from the cycle after the start strobe
    assign tx_busy = (state != IDLE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            cnt     <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else if (state == IDLE) begin
            if (tx_start) begin
                state <= START;
                cnt   <= CNT_W'(BAUD_DIV - 1);
                txd   <= 1'b0;
            end
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else begin
            // Bit period done
            cnt <= CNT_W'(BAUD_DIV - 1);
            case (state)
                START: begin
                    state   <= DATA;
                    bit_idx <= '0;
                    txd     <= shift[0];
                end
                DATA: begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) begin
                        state <= STOP;
                        txd   <= 1'b1;
                    end else begin
                        txd <= shift[bit_idx + 1'b1];
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Byte held for the whole frame
    always_ff @(posedge clk) begin
        if (state == IDLE && tx_start) begin
            shift <= tx_data;
        end
    end

endmodule

// ==== rtl/cmd_bridge.sv ====
////////////////////////////////////////
// Byte command parser driving the register bus
// Bytes received during ST_BUS or ST_SEND are dropped
////////////////////////////////////////
`timescale 1ns/1ps

module cmd_bridge (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        rx_valid,
    input  logic [7:0]  rx_data,
    output logic        tx_start,
    output logic [7:0]  tx_data,
    input  logic        tx_busy,
    mouse_bus_if.master bus
);
    import mouse_pkg::*;

    // Index of the last payload byte
    localparam logic [1:0] LAST = 2'(GPIO_W / 8 - 1);

    bridge_state_e     state;
    cmd_op_e           op;
    logic [ADDR_W-1:0] addr;
    logic [GPIO_W-1:0] word;
    logic [1:0]        cnt;
    logic              last_byte;

    // Write answers with one ACK, read with the whole word
    assign last_byte = (op == OP_WRITE) || (cnt == LAST);

    // Transmitter fed whenever it is idle
    assign tx_start = (state == ST_SEND) && !tx_busy;
    assign tx_data  = (op == OP_WRITE) ? ACK_BYTE : word[7:0];

    // Bus request fields
    assign bus.wen   = (op == OP_WRITE);
    assign bus.addr  = addr;
    assign bus.wdata = word;

    ////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= ST_CMD;
            op      <= OP_READ;
            addr    <= '0;
            cnt     <= '0;
            bus.req <= 1'b0;
        end else begin
            bus.req <= 1'b0;
            case (state)
                ST_CMD: begin
                    if (rx_valid) begin
                        op   <= cmd_op_e'(rx_data[7]);
                        addr <= rx_data[ADDR_W-1:0];
                        cnt  <= '0;
                        if (rx_data[7]) begin
                            state <= ST_DATA;
                        end else begin
                            // Read goes straight to the bus
                            state   <= ST_BUS;
                            bus.req <= 1'b1;
                        end
                    end
                end
                ST_DATA: begin
                    if (rx_valid) begin
                        cnt <= cnt + 1'b1;
                        if (cnt == LAST) begin
                            state   <= ST_BUS;
                            bus.req <= 1'b1;
                        end
                    end
                end
                ST_BUS: begin
                    // Write done on the req edge, read waits for rvalid
                    if (op == OP_WRITE || bus.rvalid) begin
                        state <= ST_SEND;
                    end
                end
                default: begin
                    if (tx_start) begin
                        if (last_byte) begin
                            state <= ST_CMD;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Data word
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == ST_DATA && rx_valid) begin
            // LSB first
            word <= {rx_data, word[GPIO_W-1:8]};
        end else if (state == ST_BUS && bus.rvalid) begin
            word <= bus.rdata;
        end else if (tx_start) begin
            word <= word >> 8;
        end
    end

endmodule

// ==== rtl/gpio_regs.sv ====
////////////////////////////////////////
// GPIO output, enable and input registers
// Pin inputs reach REG_IN two cycles after they change
////////////////////////////////////////
`timescale 1ns/1ps

module gpio_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    mouse_bus_if.slave                bus,
    input  logic [mouse_pkg::GPIO_W-1:0] gpio_i,
    output logic [mouse_pkg::GPIO_W-1:0] gpio_o,
    output logic [mouse_pkg::GPIO_W-1:0] gpio_e
);
    import mouse_pkg::*;

    logic [GPIO_W-1:0] in_meta;
    logic [GPIO_W-1:0] in_sync;
    logic [GPIO_W-1:0] rd_mux;

    // Register writes, REG_IN and unmapped ignored
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gpio_o     <= '0;
            gpio_e     <= '0;
            bus.rvalid <= 1'b0;
        end else begin
            bus.rvalid <= bus.req & ~bus.wen;
            if (bus.req && bus.wen) begin
                case (gpio_reg_e'(bus.addr))
                    REG_OUT: gpio_o <= bus.wdata;
                    REG_OE:  gpio_e <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

    // Pin input synchronizer
    always_ff @(posedge clk) begin
        in_meta <= gpio_i;
        in_sync <= in_meta;
    end

    // Read mux
    always_comb begin
        case (gpio_reg_e'(bus.addr))
            REG_OUT:  rd_mux = gpio_o;
            REG_OE:   rd_mux = gpio_e;
            REG_IN:   rd_mux = in_sync;
            REG_NONE: rd_mux = '0;
            default:  rd_mux = '0;
        endcase
    end

    // Data one cycle after req
    always_ff @(posedge clk) begin
        if (bus.req && !bus.wen) begin
            bus.rdata <= rd_mux;
        end
    end

endmodule

// ==== rtl/mouse_soc_top.sv ====
////////////////////////////////////////
// System top, UART command bridge and GPIO registers
////////////////////////////////////////
`timescale 1ns/1ps

module mouse_soc_top #(
    parameter int unsigned BAUD_DIV = 868
)(
    input  logic                         clk,
    input  logic                         rst_n,
    output logic [mouse_pkg::GPIO_W-1:0] gpio_o,
    output logic [mouse_pkg::GPIO_W-1:0] gpio_e,
    input  logic [mouse_pkg::GPIO_W-1:0] gpio_i,
    output logic                         uart_txd,
    input  logic                         uart_rxd
);

    // UART byte streams
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       tx_start;
    logic [7:0] tx_data;
    logic       tx_busy;

    // Bridge to GPIO register bus
    mouse_bus_if bus ();

    uart_rx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rxd      (uart_rxd),
        .rx_valid (rx_valid),
        .rx_data  (rx_data)
    );

    uart_tx #(
        .BAUD_DIV (BAUD_DIV)
    ) u_tx (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .txd      (uart_txd),
        .tx_busy  (tx_busy)
    );

    cmd_bridge u_bridge (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .tx_start (tx_start),
        .tx_data  (tx_data),
        .tx_busy  (tx_busy),
        .bus      (bus.master)
    );

    gpio_regs u_gpio (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus    (bus.slave),
        .gpio_i (gpio_i),
        .gpio_o (gpio_o),
        .gpio_e (gpio_e)
    );

endmodule

// ==== rtl/mouse_soc_arty.sv ====
////////////////////////////////////////
// Arty board top, board clock used directly
// Only the lower GPIO_W pins are driven, the rest float
////////////////////////////////////////
`timescale 1ns/1ps

module mouse_soc_arty #(
    parameter int unsigned BAUD_DIV    = 868,
    parameter int unsigned SYNC_STAGES = 4
)(
    input  logic                             CLK100MHZ,
    input  logic                             rst_n,
    inout  wire  [mouse_pkg::BOARD_IO_W-1:0] ck_io,
    output logic                             uart_rxd_out,
    input  logic                             uart_txd_in
);
    import mouse_pkg::*;

    logic                   clk;
    logic [SYNC_STAGES-1:0] rst_sync;
    logic                   sys_rst_n;
    logic [GPIO_W-1:0]      gpio_o;
    logic [GPIO_W-1:0]      gpio_e;
    logic [GPIO_W-1:0]      gpio_i;

    // No PLL
    assign clk = CLK100MHZ;

    ////////////////////////////////////////
    // Reset synchronizer
    ////////////////////////////////////////

    // Async assert, release after SYNC_STAGES clocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_sync <= '0;
        end else begin
            rst_sync <= {rst_sync[SYNC_STAGES-2:0], 1'b1};
        end
    end

    assign sys_rst_n = rst_sync[SYNC_STAGES-1];

    ////////////////////////////////////////
    // Pins
    ////////////////////////////////////////

    // Tristate per pin, enable from REG_OE
    for (genvar i = 0; i < GPIO_W; i++) begin : g_pin
        assign ck_io[i] = gpio_e[i] ? gpio_o[i] : 1'bz;
    end

    // Unused pins
    assign ck_io[BOARD_IO_W-1:GPIO_W] = 'z;

    // Own outputs read back too
    assign gpio_i = ck_io[GPIO_W-1:0];

    mouse_soc_top #(
        .BAUD_DIV (BAUD_DIV)
    ) u_soc (
        .clk      (clk),
        .rst_n    (sys_rst_n),
        .gpio_o   (gpio_o),
        .gpio_e   (gpio_e),
        .gpio_i   (gpio_i),
        .uart_txd (uart_rxd_out),
        .uart_rxd (uart_txd_in)
    );

endmodule

// ==== tb/tb_mouse_soc_arty.sv ====
////////////////////////////////////////
// Board-level testbench, host UART at 16 clocks per bit
// Upper pins are driven only here, so any DUT driver on them collides
////////////////////////////////////////
`timescale 1ns/1ps

module tb_mouse_soc_arty;
    import mouse_pkg::*;

    localparam int BIT_CYC    = 16;
    localparam int SYNC_DEPTH = 4;
    localparam int N_FIXED    = 12;
    localparam int N_RAND     = 20;
    localparam int N_ENTRIES  = N_FIXED + N_RAND;
    localparam int UP_W       = BOARD_IO_W - GPIO_W;
    // Worst case 6 frames per entry, doubled
    localparam int MAX_CYCLES = N_ENTRIES * 6 * 10 * BIT_CYC * 2;

    logic                  CLK100MHZ;
    logic                  rst_n;
    logic                  uart_txd_in;
    wire                   uart_rxd_out;
    wire  [BOARD_IO_W-1:0] ck_io;
    logic [GPIO_W-1:0]     tb_pins;
    // 1 where the testbench releases the pin
    logic [GPIO_W-1:0]     tb_oe;
    logic [31:0]           lcg_state;
    int                    cycles;

    // Stimulus table plus model state after each entry
    cmd_op_e     t_op    [N_ENTRIES];
    logic [1:0]  t_addr  [N_ENTRIES];
    logic [31:0] t_wdata [N_ENTRIES];
    logic [31:0] t_pins  [N_ENTRIES];
    logic [31:0] t_exp   [N_ENTRIES];
    logic [31:0] t_out   [N_ENTRIES];
    logic [31:0] t_oe    [N_ENTRIES];

    mouse_soc_arty #(
        .BAUD_DIV    (BIT_CYC),
        .SYNC_STAGES (SYNC_DEPTH)
    ) uut (
        .CLK100MHZ    (CLK100MHZ),
        .rst_n        (rst_n),
        .ck_io        (ck_io),
        .uart_rxd_out (uart_rxd_out),
        .uart_txd_in  (uart_txd_in)
    );

    // Pin driver, off where the DUT may drive
    for (genvar i = 0; i < GPIO_W; i++) begin : g_drv
        assign ck_io[i] = tb_oe[i] ? 1'bz : tb_pins[i];
    end

    // Upper pins read back the testbench value when the DUT leaves them floating
    assign ck_io[BOARD_IO_W-1:GPIO_W] = tb_pins[UP_W-1:0];

    always #50 CLK100MHZ = ~CLK100MHZ;

    // Cycle limit
    always @(posedge CLK100MHZ) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: no response within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "run aborted on timeout");
        end
    end

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s, got %h, expected %h",
                     $time, msg, actual, expected);
            $display("Test failed");
            $fatal(1, "stopping at first error");
        end
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    // Upper halves only, low LCG bits are weak
    function automatic logic [31:0] rand_word();
        logic [31:0] a;
        logic [31:0] b;
        a = lcg_next();
        b = lcg_next();
        return {a[31:16], b[31:16]};
    endfunction

    task automatic set_entry(input int k, input cmd_op_e op, input logic [1:0] addr,
                             input logic [31:0] wdata, input logic [31:0] pins);
        t_op[k]    = op;
        t_addr[k]  = addr;
        t_wdata[k] = wdata;
        t_pins[k]  = pins;
    endtask

    ////////////////////////////////////////
    // Table and expected values
    ////////////////////////////////////////

    task automatic fill_table();
        logic [31:0] r;
        // Reset values, write and readback, pins, ignored writes
        set_entry(0,  OP_READ,  2'd0, 32'h0,         32'h0F0F_5A5A);
        set_entry(1,  OP_READ,  2'd1, 32'h0,         32'h0F0F_5A5A);
        set_entry(2,  OP_WRITE, 2'd0, 32'hA5C3_0F96, 32'h0F0F_5A5A);
        set_entry(3,  OP_READ,  2'd0, 32'h0,         32'h0F0F_5A5A);
        set_entry(4,  OP_WRITE, 2'd1, 32'h0000_FFFF, 32'h1234_5678);
        set_entry(5,  OP_READ,  2'd1, 32'h0,         32'h1234_5678);
        set_entry(6,  OP_READ,  2'd2, 32'h0,         32'h1234_5678);
        set_entry(7,  OP_WRITE, 2'd2, 32'hFFFF_FFFF, 32'hCAFE_0001);
        set_entry(8,  OP_WRITE, 2'd3, 32'hDEAD_BEEF, 32'hCAFE_0001);
        set_entry(9,  OP_READ,  2'd3, 32'h0,         32'hCAFE_0001);
        set_entry(10, OP_READ,  2'd0, 32'h0,         32'h8421_7E7E);
        set_entry(11, OP_READ,  2'd1, 32'h0,         32'h8421_7E7E);
        for (int k = N_FIXED; k < N_ENTRIES; k++) begin
            r = lcg_next();
            set_entry(k, cmd_op_e'(r[31]), r[17:16], rand_word(), rand_word());
        end
    endtask

    // Register model, REG_IN and unmapped writes dropped
    task automatic build_expected();
        logic [31:0] out_m;
        logic [31:0] oe_m;
        out_m = '0;
        oe_m  = '0;
        for (int k = 0; k < N_ENTRIES; k++) begin
            if (t_op[k] == OP_WRITE) begin
                if (t_addr[k] == 2'd0) out_m = t_wdata[k];
                if (t_addr[k] == 2'd1) oe_m = t_wdata[k];
                t_exp[k] = 32'(ACK_BYTE);
            end else begin
                case (t_addr[k])
                    2'd0:    t_exp[k] = out_m;
                    2'd1:    t_exp[k] = oe_m;
                    2'd2:    t_exp[k] = (out_m & oe_m) | (t_pins[k] & ~oe_m);
                    default: t_exp[k] = '0;
                endcase
            end
            t_out[k] = out_m;
            t_oe[k]  = oe_m;
        end
    endtask

    ////////////////////////////////////////
    // Host UART model
    ////////////////////////////////////////

    // Entered and left 1 ns after a rising edge
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_txd_in = frame[i];
            repeat (BIT_CYC) @(posedge CLK100MHZ);
            #1;
        end
    endtask

    // Sampled on falling edges, away from DUT updates
    task automatic recv_byte(output logic [7:0] b);
        @(negedge CLK100MHZ);
        while (uart_rxd_out !== 1'b0) @(negedge CLK100MHZ);
        repeat (BIT_CYC / 2) @(negedge CLK100MHZ);
        check(32'(uart_rxd_out), 32'd0, "start bit");
        for (int i = 0; i < 8; i++) begin
            repeat (BIT_CYC) @(negedge CLK100MHZ);
            b[i] = uart_rxd_out;
        end
        repeat (BIT_CYC) @(negedge CLK100MHZ);
        check(32'(uart_rxd_out), 32'd1, "stop bit");
    endtask

    task automatic run_entry(input int k);
        logic [7:0]  cmd;
        logic [7:0]  b;
        logic [31:0] resp;
        int          n;
        cmd     = {t_op[k], 5'b0, t_addr[k]};
        n       = (t_op[k] == OP_WRITE) ? 1 : 4;
        resp    = '0;
        tb_pins = t_pins[k];
        // Release both old and new DUT-driven pins while REG_OE may change
        tb_oe   = tb_oe | t_oe[k];
        fork
            begin
                send_byte(cmd);
                if (t_op[k] == OP_WRITE) begin
                    for (int i = 0; i < 4; i++) send_byte(t_wdata[k][8*i +: 8]);
                end
            end
            begin
                for (int j = 0; j < n; j++) begin
                    recv_byte(b);
                    resp[8*j +: 8] = b;
                end
            end
        join
        check(resp, t_exp[k], $sformatf("entry %0d response", k));
        @(posedge CLK100MHZ);
        #1;
        tb_oe = t_oe[k];
        repeat (3) @(posedge CLK100MHZ);
        #1;
        check(ck_io[GPIO_W-1:0], (t_out[k] & t_oe[k]) | (t_pins[k] & ~t_oe[k]),
              $sformatf("entry %0d pins", k));
        check(32'(ck_io[BOARD_IO_W-1:GPIO_W]), 32'(t_pins[k][UP_W-1:0]),
              $sformatf("entry %0d upper pins", k));
    endtask

    initial begin
        CLK100MHZ   = 1'b0;
        rst_n       = 1'b0;
        uart_txd_in = 1'b1;
        tb_pins     = '0;
        tb_oe       = '0;
        lcg_state   = 32'd20010;
        cycles      = 0;
        fill_table();
        build_expected();
        repeat (3) @(posedge CLK100MHZ);
        #1;
        rst_n = 1'b1;
        // Internal reset release plus margin
        repeat (SYNC_DEPTH + 2) @(posedge CLK100MHZ);
        #1;
        check(32'(uart_rxd_out), 32'd1, "idle tx line");
        for (int k = 0; k < N_ENTRIES; k++) begin
            run_entry(k);
        end
        $display("Test passed");
        $finish;
    end

endmodule

// ==== src.f ====
common/mouse_pkg.sv
common/mouse_bus_if.sv
uart/uart_rx.sv
uart/uart_tx.sv
rtl/cmd_bridge.sv
rtl/gpio_regs.sv
rtl/mouse_soc_top.sv
rtl/mouse_soc_arty.sv
tb/tb_mouse_soc_arty.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the board-level simulation with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mouse_soc_arty -f src.f -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
